/* lac_sparse_mul.f */
+incdir+source
+incdir+testbench
source/lac_sparse_mul_pkg.sv
source/lac_ram.sv
source/lac_loop_ctrl.sv
source/lac_rotate_stage.sv
source/lac_sum_reduce.sv
source/lac_accumulate.sv
source/lac_sparse_mul.sv
testbench/lac_sparse_mul_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the sparse multiplier testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
  --top-module lac_sparse_mul_tb -f lac_sparse_mul.f \
  --Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi
exit 0

/* testbench/lac_sparse_mul_model.svh */
// reference model of the sparse product, LCG helpers and the value compare task
`ifndef LAC_SPARSE_MUL_MODEL_SVH
`define LAC_SPARSE_MUL_MODEL_SVH

// 32-bit linear congruential generator
function automatic int unsigned lcg_next(input int unsigned state);
  return state * 32'd1103515245 + 32'd12345;
endfunction

// advance the generator and keep its upper bits
function automatic int rand_below(input int bound);
  lcg_state = lcg_next(lcg_state);
  return int'(lcg_state >> 8) % bound;
endfunction

// reference product c = a * s mod (x^N + 1)
// a[i] * x^p lands on i + p and changes sign once it passes x^N
task automatic compute_expected();
  int dst;
  bit neg;
  for (int m = 0; m < `LAC_N; m++)
    exp_c[m] = 0;
  for (int k = 0; k < `LAC_H; k++)
  begin
    for (int i = 0; i < `LAC_N; i++)
    begin
      dst = i + s_pos[k];
      // second half of the positions carries -1
      neg = (k >= `LAC_H / 2);
      if (dst >= `LAC_N)
      begin
        dst = dst - `LAC_N;
        neg = !neg;
      end
      if (neg)
        exp_c[dst] = (exp_c[dst] + `LAC_Q - a_poly[i]) % `LAC_Q;
      else
        exp_c[dst] = (exp_c[dst] + a_poly[i]) % `LAC_Q;
    end
  end
endtask

task automatic check_value(input string sig_name, input logic [31:0] got,
                           input logic [31:0] expected);
  if (got !== expected)
  begin
    $display("Error at %0d ns: %s is %0d, expected %0d", $time, sig_name, got, expected);
    err_cnt++;
    test_err++;
  end
endtask

`endif

/* testbench/lac_sparse_mul_tb.sv */
// testbench for the sparse multiplier: clock, reset, test table, runs, watchdog and summary
`timescale 1ns/1ps
`default_nettype none

`include "lac_sparse_mul_settings.svh"

module lac_sparse_mul_tb;

  import lac_sparse_mul_pkg::*;

  localparam int NUM_TESTS  = 5;
  localparam int GROUPS     = `LAC_H / `LAC_CORES;
  localparam int HALF_N     = `LAC_N / 2;
  localparam int RUN_CYCLES = GROUPS * (HALF_N + 16) + 2 * `LAC_N;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 2 * RUN_CYCLES;

  // dense and position pattern kinds
  localparam int DK_RANDOM = 0;
  localparam int DK_MAX    = 1;
  localparam int PK_RANDOM = 0;
  localparam int PK_EQUAL  = 1;
  localparam int PK_EDGE   = 2;

  // --------------------
  // test table
  string test_name [NUM_TESTS] = '{"equal_pos", "wrap_edge", "random_a", "random_b",
                                   "max_coeff"};
  int    dense_kind [NUM_TESTS]  = '{DK_RANDOM, DK_RANDOM, DK_RANDOM, DK_RANDOM, DK_MAX};
  int    pos_kind [NUM_TESTS]    = '{PK_EQUAL, PK_EDGE, PK_RANDOM, PK_RANDOM, PK_RANDOM};
  int    seed_offset [NUM_TESTS] = '{0, 3, 7, 13, 21};
  // rows whose result must be all zero
  bit    all_zero [NUM_TESTS]    = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0};

  logic        clk;
  logic        rst_n;
  logic        start;
  logic        busy;
  logic        done;
  logic        poly_wr_en;
  poly_addr_t  poly_wr_addr;
  coeff_pair_t poly_wr_data;
  logic        pos_wr_en;
  group_addr_t pos_wr_addr;
  pos_group_t  pos_wr_data;
  logic        res_rd_en;
  pair_addr_t  res_rd_addr;
  coeff_pair_t res_rd_data;

  int          a_poly [`LAC_N];
  int          s_pos [`LAC_H];
  int          exp_c [`LAC_N];
  int unsigned lcg_state;
  int          err_cnt;
  int          test_err;
  int          fail_tests;

  `include "lac_sparse_mul_model.svh"

  lac_sparse_mul i_lac_sparse_mul (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .busy        (busy),
    .done        (done),
    .poly_wr_en  (poly_wr_en),
    .poly_wr_addr(poly_wr_addr),
    .poly_wr_data(poly_wr_data),
    .pos_wr_en   (pos_wr_en),
    .pos_wr_addr (pos_wr_addr),
    .pos_wr_data (pos_wr_data),
    .res_rd_en   (res_rd_en),
    .res_rd_addr (res_rd_addr),
    .res_rd_data (res_rd_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * 20);
    $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  // --------------------
  // stimulus
  task automatic make_operands(input int row);
    int p;
    lcg_state = 32'd46116 + seed_offset[row];
    for (int i = 0; i < `LAC_N; i++)
      a_poly[i] = (dense_kind[row] == DK_MAX) ? `LAC_Q - 1 : rand_below(`LAC_Q);
    p = rand_below(`LAC_N);
    for (int k = 0; k < `LAC_H; k++)
    begin
      case (pos_kind[row])
        PK_EQUAL: s_pos[k] = p;
        PK_EDGE:  s_pos[k] = (k < `LAC_H / 2) ? 0 : `LAC_N - 1;
        default:  s_pos[k] = rand_below(`LAC_N);
      endcase
    end
  endtask

  task automatic load_memories();
    for (int i = 0; i < `LAC_N; i++)
    begin
      @(posedge clk);
      poly_wr_en   <= 1'b1;
      poly_wr_addr <= poly_addr_t'(i);
      poly_wr_data <= '{hi: coeff_t'(a_poly[(i + 1) % `LAC_N]), lo: coeff_t'(a_poly[i])};
    end
    for (int g = 0; g < GROUPS; g++)
    begin
      @(posedge clk);
      poly_wr_en  <= 1'b0;
      pos_wr_en   <= 1'b1;
      pos_wr_addr <= group_addr_t'(g);
      for (int j = 0; j < `LAC_CORES; j++)
        pos_wr_data[j] <= pos_t'(s_pos[g * `LAC_CORES + j]);
    end
    @(posedge clk);
    pos_wr_en <= 1'b0;
  endtask

  // back to back reads
  // pair k shows up two edges after its read is driven
  task automatic read_results(input int row);
    int expect_lo;
    int expect_hi;
    for (int k = 0; k < HALF_N + 2; k++)
    begin
      @(posedge clk);
      res_rd_en   <= (k < HALF_N);
      res_rd_addr <= pair_addr_t'(k);
      @(negedge clk);
      if (k >= 2)
      begin
        expect_lo = all_zero[row] ? 0 : exp_c[2 * (k - 2)];
        expect_hi = all_zero[row] ? 0 : exp_c[2 * (k - 2) + 1];
        check_value($sformatf("res_rd_data[%0d].lo", k - 2), res_rd_data.lo, expect_lo);
        check_value($sformatf("res_rd_data[%0d].hi", k - 2), res_rd_data.hi, expect_hi);
      end
    end
  endtask

  task automatic report_test(input string name);
    if (test_err == 0)
      $display("test %s: ok", name);
    else
    begin
      $display("test %s: %0d errors", name, test_err);
      fail_tests++;
    end
  endtask

  task automatic run_test(input int row);
    int waited;
    test_err = 0;
    make_operands(row);
    compute_expected();
    load_memories();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_value("busy", busy, 1);
    waited = 0;
    while (done !== 1'b1 && waited < RUN_CYCLES)
    begin
      @(negedge clk);
      waited++;
    end
    if (done !== 1'b1)
    begin
      $display("test %s: done never came after start", test_name[row]);
      err_cnt++;
      test_err++;
    end
    else
    begin
      // busy falls on the same edge that raises done
      check_value("busy", busy, 0);
      @(negedge clk);
      check_value("done", done, 0);
      check_value("busy", busy, 0);
    end
    read_results(row);
    report_test(test_name[row]);
  endtask

  // --------------------
  // main sequence
  initial
  begin
    rst_n        = 1'b0;
    start        = 1'b0;
    poly_wr_en   = 1'b0;
    poly_wr_addr = '0;
    poly_wr_data = '0;
    pos_wr_en    = 1'b0;
    pos_wr_addr  = '0;
    pos_wr_data  = '0;
    res_rd_en    = 1'b0;
    res_rd_addr  = '0;
    err_cnt      = 0;
    fail_tests   = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // idle after reset without a start
    test_err = 0;
    repeat (20)
    begin
      @(negedge clk);
      check_value("busy", busy, 0);
      check_value("done", done, 0);
    end
    report_test("idle_after_reset");

    for (int row = 0; row < NUM_TESTS; row++)
      run_test(row);

    $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS + 1, fail_tests, err_cnt);
    if (err_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* source/lac_sparse_mul.sv */
// top level of the sparse polynomial multiplier: sequencer, position memory and datapath
`timescale 1ns/1ps
`default_nettype none

`include "lac_sparse_mul_settings.svh"

module lac_sparse_mul (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            start,
  output logic                            busy,
  output logic                            done,
  // dense polynomial load
  input  logic                            poly_wr_en,
  input  lac_sparse_mul_pkg::poly_addr_t  poly_wr_addr,
  input  lac_sparse_mul_pkg::coeff_pair_t poly_wr_data,
  // position groups load
  input  logic                            pos_wr_en,
  input  lac_sparse_mul_pkg::group_addr_t pos_wr_addr,
  input  lac_sparse_mul_pkg::pos_group_t  pos_wr_data,
  // result read
  input  logic                            res_rd_en,
  input  lac_sparse_mul_pkg::pair_addr_t  res_rd_addr,
  output lac_sparse_mul_pkg::coeff_pair_t res_rd_data
);

  import lac_sparse_mul_pkg::*;

  group_addr_t pos_rd_addr;
  pos_group_t  pos_rd_data;
  logic        pos_valid;
  beat_t       beat;
  rot_beat_t   rot;
  sum_beat_t   sum;
  logic        group_written;

  lac_loop_ctrl i_loop_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .busy         (busy),
    .done         (done),
    .pos_rd_addr  (pos_rd_addr),
    .pos_valid    (pos_valid),
    .beat         (beat),
    .group_written(group_written)
  );

  // one word per group of positions
  lac_ram #(
    .payload_t(pos_group_t),
    .DEPTH    (`LAC_H / `LAC_CORES)
  ) i_pos_ram (
    .clk    (clk),
    .wr_en  (pos_wr_en),
    .wr_addr(pos_wr_addr),
    .wr_data(pos_wr_data),
    .rd_addr(pos_rd_addr),
    .rd_data(pos_rd_data)
  );

  lac_rotate_stage i_rotate_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .poly_wr_en  (poly_wr_en),
    .poly_wr_addr(poly_wr_addr),
    .poly_wr_data(poly_wr_data),
    .pos_data    (pos_rd_data),
    .pos_valid   (pos_valid),
    .beat_in     (beat),
    .rot_out     (rot)
  );

  lac_sum_reduce i_sum_reduce (
    .clk    (clk),
    .rst_n  (rst_n),
    .rot_in (rot),
    .sum_out(sum)
  );

  lac_accumulate i_accumulate (
    .clk          (clk),
    .rst_n        (rst_n),
    .sum_in       (sum),
    .group_written(group_written),
    .res_rd_en    (res_rd_en),
    .res_rd_addr  (res_rd_addr),
    .res_rd_data  (res_rd_data)
  );

endmodule

`default_nettype wire

/* source/lac_accumulate.sv */
// result memory, read-add-reduce-write loop and the external read port
`timescale 1ns/1ps
`default_nettype none

`include "lac_sparse_mul_settings.svh"

module lac_accumulate (
  input  logic                            clk,
  input  logic                            rst_n,
  input  lac_sparse_mul_pkg::sum_beat_t   sum_in,
  output logic                            group_written,
  input  logic                            res_rd_en,
  input  lac_sparse_mul_pkg::pair_addr_t  res_rd_addr,
  output lac_sparse_mul_pkg::coeff_pair_t res_rd_data
);

  import lac_sparse_mul_pkg::*;

  localparam int ACC_W = `LAC_COEFF_W + 1;

  beat_t            rd_beat;
  coeff_pair_t      rd_new;
  beat_t            add_beat;
  logic [ACC_W-1:0] add_lo;
  logic [ACC_W-1:0] add_hi;
  pair_addr_t       mem_rd_addr;
  coeff_pair_t      mem_rd_data;
  coeff_pair_t      old_pair;
  coeff_pair_t      wr_pair;
  logic             in_flight;
  logic             ext_rd_q;

  // beats own the read port, outside reads only get it when nothing is moving
  assign in_flight   = sum_in.beat.valid | rd_beat.valid | add_beat.valid;
  assign mem_rd_addr = sum_in.beat.valid ? sum_in.beat.pair_idx : res_rd_addr;

  lac_ram #(
    .payload_t(coeff_pair_t),
    .DEPTH    (`LAC_N / 2)
  ) i_res_ram (
    .clk    (clk),
    .wr_en  (add_beat.valid),
    .wr_addr(add_beat.pair_idx),
    .wr_data(wr_pair),
    .rd_addr(mem_rd_addr),
    .rd_data(mem_rd_data)
  );

  // the first group starts from zero instead of the previous run's result
  assign old_pair = rd_beat.first_group ? '0 : mem_rd_data;

  // --------------------
  // subtract once, both inputs are below Q
  assign wr_pair.lo = (add_lo >= ACC_W'(`LAC_Q)) ? coeff_t'(add_lo - ACC_W'(`LAC_Q))
                                                 : coeff_t'(add_lo);
  assign wr_pair.hi = (add_hi >= ACC_W'(`LAC_Q)) ? coeff_t'(add_hi - ACC_W'(`LAC_Q))
                                                 : coeff_t'(add_hi);

  always_ff @(posedge clk)
  begin
    rd_new <= sum_in.pair;
    add_lo <= ACC_W'(old_pair.lo) + ACC_W'(rd_new.lo);
    add_hi <= ACC_W'(old_pair.hi) + ACC_W'(rd_new.hi);
    if (ext_rd_q)
      res_rd_data <= mem_rd_data;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      rd_beat       <= '0;
      add_beat      <= '0;
      group_written <= 1'b0;
      ext_rd_q      <= 1'b0;
    end
    else
    begin
      rd_beat       <= sum_in.beat;
      add_beat      <= rd_beat;
      group_written <= add_beat.valid & add_beat.last;
      ext_rd_q      <= res_rd_en & ~in_flight;
    end
  end

endmodule

`default_nettype wire

/* source/lac_sum_reduce.sv */
// adder across the cores and the two-step reduction modulo Q
`timescale 1ns/1ps
`default_nettype none

`include "lac_sparse_mul_settings.svh"

module lac_sum_reduce (
  input  logic                          clk,
  input  logic                          rst_n,
  input  lac_sparse_mul_pkg::rot_beat_t rot_in,
  output lac_sparse_mul_pkg::sum_beat_t sum_out
);

  import lac_sparse_mul_pkg::*;

  // one spare bit keeps the upper slice non-empty even for a single core
  localparam int SUM_W  = `LAC_COEFF_W + $clog2(`LAC_CORES) + 1;
  localparam int FOLD_W = `LAC_COEFF_W + 1;

  logic [SUM_W-1:0]  lane_sum_lo;
  logic [SUM_W-1:0]  lane_sum_hi;
  logic [SUM_W-1:0]  sum_lo_q;
  logic [SUM_W-1:0]  sum_hi_q;
  logic [FOLD_W-1:0] fold_lo_q;
  logic [FOLD_W-1:0] fold_hi_q;
  coeff_pair_t       red_q;
  beat_t             beat_s1;
  beat_t             beat_s2;
  beat_t             beat_s3;

  // upper bits weigh 2^COEFF_W, which is LAC_FOLD mod Q
  function automatic logic [FOLD_W-1:0] fold(input logic [SUM_W-1:0] s);
    logic [FOLD_W-1:0] high;
    high = FOLD_W'(s[SUM_W-1:`LAC_COEFF_W]);
    return high * FOLD_W'(`LAC_FOLD) + FOLD_W'(s[`LAC_COEFF_W-1:0]);
  endfunction

  function automatic coeff_t sub_q(input logic [FOLD_W-1:0] v);
    return (v >= FOLD_W'(`LAC_Q)) ? coeff_t'(v - FOLD_W'(`LAC_Q)) : coeff_t'(v);
  endfunction

  always_comb
  begin
    lane_sum_lo = '0;
    lane_sum_hi = '0;
    for (int j = 0; j < `LAC_CORES; j++)
    begin
      lane_sum_lo = lane_sum_lo + SUM_W'(rot_in.lanes[j].lo);
      lane_sum_hi = lane_sum_hi + SUM_W'(rot_in.lanes[j].hi);
    end
  end

  // adder, fold and subtract registers
  always_ff @(posedge clk)
  begin
    sum_lo_q  <= lane_sum_lo;
    sum_hi_q  <= lane_sum_hi;
    fold_lo_q <= fold(sum_lo_q);
    fold_hi_q <= fold(sum_hi_q);
    red_q.lo  <= sub_q(fold_lo_q);
    red_q.hi  <= sub_q(fold_hi_q);
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      beat_s1 <= '0;
      beat_s2 <= '0;
      beat_s3 <= '0;
    end
    else
    begin
      beat_s1 <= rot_in.beat;
      beat_s2 <= beat_s1;
      beat_s3 <= beat_s2;
    end
  end

  assign sum_out = '{beat: beat_s3, pair: red_q};

endmodule

`default_nettype wire

/* source/lac_rotate_stage.sv */
// per-core dense copies, latched positions, rotated read addresses and sign correction
`timescale 1ns/1ps
`default_nettype none

`include "lac_sparse_mul_settings.svh"

module lac_rotate_stage (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            poly_wr_en,
  input  lac_sparse_mul_pkg::poly_addr_t  poly_wr_addr,
  input  lac_sparse_mul_pkg::coeff_pair_t poly_wr_data,
  input  lac_sparse_mul_pkg::pos_group_t  pos_data,
  input  logic                            pos_valid,
  input  lac_sparse_mul_pkg::beat_t       beat_in,
  output lac_sparse_mul_pkg::rot_beat_t   rot_out
);

  import lac_sparse_mul_pkg::*;

  pos_group_t  pos_q;
  poly_addr_t  rd_addr [`LAC_CORES];
  coeff_pair_t ram_out [`LAC_CORES];
  beat_t       beat_d1;
  beat_t       beat_q;
  lane_pairs_t lanes_fix;
  lane_pairs_t lanes_q;
  pos_t        even_idx;
  pos_t        odd_idx;

  // positions stay put for the whole group
  always_ff @(posedge clk)
  begin
    if (pos_valid)
      pos_q <= pos_data;
  end

  // --------------------
  // dense copies, one per core
  for (genvar j = 0; j < `LAC_CORES; j++)
  begin : g_core
    // a[(2*pair_idx - pos) mod N] sits in the lo half of this word
    assign rd_addr[j] = {beat_in.pair_idx, 1'b0} - pos_q[j];

    lac_ram #(
      .payload_t(coeff_pair_t),
      .DEPTH    (`LAC_N)
    ) i_dense_ram (
      .clk    (clk),
      .wr_en  (poly_wr_en),
      .wr_addr(poly_wr_addr),
      .wr_data(poly_wr_data),
      .rd_addr(rd_addr[j]),
      .rd_data(ram_out[j])
    );
  end

  // --------------------
  // sign correction
  assign even_idx = {beat_d1.pair_idx, 1'b0};
  assign odd_idx  = {beat_d1.pair_idx, 1'b1};

  // wrapped terms pick up a minus from x^N = -1, the -1 half flips it again
  always_comb
  begin
    for (int j = 0; j < `LAC_CORES; j++)
    begin
      lanes_fix[j] = ram_out[j];
      if ((even_idx < pos_q[j]) ^ beat_d1.negate)
        lanes_fix[j].lo = coeff_t'(`LAC_Q) - ram_out[j].lo;
      if ((odd_idx < pos_q[j]) ^ beat_d1.negate)
        lanes_fix[j].hi = coeff_t'(`LAC_Q) - ram_out[j].hi;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      beat_d1 <= '0;
      beat_q  <= '0;
    end
    else
    begin
      beat_d1 <= beat_in;
      beat_q  <= beat_d1;
    end
  end

  always_ff @(posedge clk)
  begin
    lanes_q <= lanes_fix;
  end

  assign rot_out = '{beat: beat_q, lanes: lanes_q};

endmodule

`default_nettype wire

/* source/lac_loop_ctrl.sv */
// run sequencer: busy/done, group and pair counters, position fetch and beat issue
`timescale 1ns/1ps
`default_nettype none

`include "lac_sparse_mul_settings.svh"

module lac_loop_ctrl (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            start,
  output logic                            busy,
  output logic                            done,
  output lac_sparse_mul_pkg::group_addr_t pos_rd_addr,
  output logic                            pos_valid,
  output lac_sparse_mul_pkg::beat_t       beat,
  input  logic                            group_written
);

  import lac_sparse_mul_pkg::*;

  localparam pair_addr_t  LAST_PAIR  = pair_addr_t'(`LAC_N / 2 - 1);
  localparam group_addr_t LAST_GROUP = group_addr_t'(`LAC_H / `LAC_CORES - 1);
  // groups from here on carry the -1 half of s
  localparam group_addr_t NEG_GROUP  = group_addr_t'(`LAC_H / (2 * `LAC_CORES));

  typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_ISSUE, ST_DRAIN} state_t;

  state_t      state;
  group_addr_t group_cnt;
  pair_addr_t  pair_cnt;

  assign busy        = (state != ST_IDLE);
  assign pos_rd_addr = group_cnt;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state     <= ST_IDLE;
      group_cnt <= '0;
      pair_cnt  <= '0;
      pos_valid <= 1'b0;
      done      <= 1'b0;
      beat      <= '0;
    end
    else
    begin
      // position word arrives one cycle after the fetch
      pos_valid  <= (state == ST_FETCH);
      done       <= 1'b0;
      beat.valid <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (start)
          begin
            group_cnt <= '0;
            state     <= ST_FETCH;
          end
        end
        ST_FETCH:
        begin
          pair_cnt <= '0;
          state    <= ST_ISSUE;
        end
        ST_ISSUE:
        begin
          beat.valid       <= 1'b1;
          beat.pair_idx    <= pair_cnt;
          beat.negate      <= (group_cnt >= NEG_GROUP);
          beat.first_group <= (group_cnt == '0);
          beat.last        <= (pair_cnt == LAST_PAIR);
          pair_cnt         <= pair_cnt + 1'b1;
          if (pair_cnt == LAST_PAIR)
            state <= ST_DRAIN;
        end
        ST_DRAIN:
        begin
          // wait until the group's final pair is in the result memory
          if (group_written)
          begin
            if (group_cnt == LAST_GROUP)
            begin
              done  <= 1'b1;
              state <= ST_IDLE;
            end
            else
            begin
              group_cnt <= group_cnt + 1'b1;
              state     <= ST_FETCH;
            end
          end
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/lac_ram.sv */
// simple dual-port RAM with one write port and a registered read port
`timescale 1ns/1ps
`default_nettype none

module lac_ram #(
  parameter type payload_t = logic [15:0],
  parameter int  DEPTH = 64
) (
  input  logic                     clk,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  payload_t                 wr_data,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output payload_t                 rd_data
);

  payload_t mem [DEPTH];

  // write port
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read data shows up one edge after the address
  always_ff @(posedge clk)
  begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* source/lac_sparse_mul_pkg.sv */
// coefficient, position, address and pipeline beat types of the sparse multiplier
`default_nettype none

`include "lac_sparse_mul_settings.svh"

package lac_sparse_mul_pkg;

  // --------------------
  // coefficients
  typedef logic [`LAC_COEFF_W-1:0] coeff_t;

  // word of the dense memory and of the result memory
  typedef struct packed {
    coeff_t hi;
    coeff_t lo;
  } coeff_pair_t;

  // --------------------
  // positions and addresses
  typedef logic [$clog2(`LAC_N)-1:0] pos_t;

  // lane j holds position g*CORES+j of group g
  typedef pos_t [`LAC_CORES-1:0] pos_group_t;

  typedef logic [$clog2(`LAC_N)-1:0] poly_addr_t;
  typedef logic [$clog2(`LAC_N/2)-1:0] pair_addr_t;
  typedef logic [$clog2(`LAC_H/`LAC_CORES)-1:0] group_addr_t;

  // --------------------
  // pipeline beats, one output pair each
  typedef struct packed {
    logic       valid;
    pair_addr_t pair_idx;
    logic       negate;
    logic       first_group;
    logic       last;
  } beat_t;

  typedef coeff_pair_t [`LAC_CORES-1:0] lane_pairs_t;

  typedef struct packed {
    beat_t       beat;
    lane_pairs_t lanes;
  } rot_beat_t;

  typedef struct packed {
    beat_t       beat;
    coeff_pair_t pair;
  } sum_beat_t;

endpackage

`default_nettype wire

/* source/lac_sparse_mul_settings.svh */
// modulus, polynomial sizes, core count and folding constant of the sparse multiplier
`ifndef LAC_SPARSE_MUL_SETTINGS_SVH
`define LAC_SPARSE_MUL_SETTINGS_SVH

// coefficient ring Z_Q
`define LAC_Q 251

// polynomial length and number of non-zero positions in s
`define LAC_N 64
`define LAC_H 16

// parallel cores, must divide LAC_H and stay at or below 16
`define LAC_CORES 4

// width of one coefficient
`define LAC_COEFF_W 8

// 2^LAC_COEFF_W mod LAC_Q, used to fold the bits above one coefficient
`define LAC_FOLD 5

`endif
